// File: include/qdrc_params.svh
`ifndef QDRC_PARAMS_SVH
`define QDRC_PARAMS_SVH

// Memory geometry of one QDR II device port pair

`define QDRC_DATA_WIDTH 36   // Bits per rise or fall word

`define QDRC_BW_WIDTH 4      // Byte-write enables per beat, one per 9 bits

`define QDRC_ADDR_WIDTH 21   // Burst address bits

// Read command cycle to the cycle where an on-time lane shows its fall beat
`define QDRC_READ_LATENCY 9

`define QDRC_MODEL_DEPTH 16  // Words held by the behavioral SRAM model

`endif

// File: logic/qdrc_pkg.sv
`include "qdrc_params.svh"

package qdrc_pkg;

  // One cycle of command toward the SRAM, data beat included
  typedef struct packed {
    logic                           w_n;        // Write strobe, active low
    logic                           r_n;        // Read strobe, active low
    logic [`QDRC_ADDR_WIDTH-1:0]    sa;         // Burst address
    logic [`QDRC_DATA_WIDTH-1:0]    d_rise;
    logic [`QDRC_DATA_WIDTH-1:0]    d_fall;
    logic [`QDRC_BW_WIDTH-1:0]      bw_n_rise;  // Byte writes, active low
    logic [`QDRC_BW_WIDTH-1:0]      bw_n_fall;
  } qdr_cmd_t;

  // Read data beats as seen on the SDR side
  typedef struct packed {
    logic [`QDRC_DATA_WIDTH-1:0] q_rise;
    logic [`QDRC_DATA_WIDTH-1:0] q_fall;
  } qdr_rd_t;

  // Single-cycle user request, both strobes may be set together
  typedef struct packed {
    logic                           wr;
    logic                           rd;
    logic [`QDRC_ADDR_WIDTH-1:0]    addr;
    logic [`QDRC_DATA_WIDTH-1:0]    wdata_rise;
    logic [`QDRC_DATA_WIDTH-1:0]    wdata_fall;
    logic [`QDRC_BW_WIDTH-1:0]      bw_n_rise;
    logic [`QDRC_BW_WIDTH-1:0]      bw_n_fall;
  } user_req_t;

  // Marks a read and the address it came from
  typedef struct packed {
    logic                           valid;
    logic [`QDRC_ADDR_WIDTH-1:0]    addr;
  } rd_tag_t;

endpackage

// File: logic/qdrc_phy_burst_align.sv
`timescale 1ns/1ns
`include "qdrc_params.svh"

module qdrc_phy_burst_align (
  input  logic               clk,
  input  logic               reset,
  input  logic               align_start,
  input  qdrc_pkg::qdr_rd_t  mem_rd,
  output qdrc_pkg::qdr_cmd_t cal_cmd,
  output logic               align_done,
  output logic               align_fail,
  output qdrc_pkg::qdr_rd_t  rd_aligned
);

  localparam int DW   = `QDRC_DATA_WIDTH;
  localparam int LAT  = `QDRC_READ_LATENCY;
  localparam int CAP0 = LAT + 1;  // State bit high in the expected fall-beat cycle
  localparam int CAP1 = LAT + 2;  // State bit high one cycle later

  // Bit 0 is the write cycle, bit 1 the read cycle, then one bit per cycle of flight
  logic [CAP1:0]     burst_state;
  logic [DW-1:0]     offset;      // Set for lanes that arrive one cycle late
  logic [DW-1:0]     first_fall;  // Fall word seen at the first capture point
  qdrc_pkg::qdr_rd_t rd_q;        // Read data held for one cycle

  // Picks the direct copy where sel is set and the held copy elsewhere
  function automatic logic [DW-1:0] lane_select(
    input logic [DW-1:0] held,
    input logic [DW-1:0] direct,
    input logic [DW-1:0] sel
  );
    logic [DW-1:0] result;
    for (int i = 0; i < DW; i++) begin
      result[i] = sel[i] ? direct[i] : held[i];
    end
    return result;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      burst_state <= '0;
    end else begin
      burst_state <= {burst_state[CAP1-1:0], align_start};  // Start pulse walks up the chain
    end
  end

  // Write to address zero, then read it back while the write data beat goes out
  always_comb begin
    cal_cmd.w_n       = !burst_state[0];
    cal_cmd.r_n       = !burst_state[1];
    cal_cmd.sa        = '0;
    cal_cmd.d_rise    = '0;
    cal_cmd.d_fall    = {DW{burst_state[1]}};  // All ones only on the data beat
    cal_cmd.bw_n_rise = '0;
    cal_cmd.bw_n_fall = '0;
  end

  always_ff @(posedge clk) begin
    rd_q       <= mem_rd;
    if (burst_state[CAP0]) begin
      first_fall <= mem_rd.q_fall;
    end
  end

  // A lane still high after the expected cycle came back late
  always_ff @(posedge clk) begin
    if (reset) begin
      offset     <= '1;
      align_done <= 1'b0;
      align_fail <= 1'b0;
    end else if (burst_state[CAP1] && !align_done) begin
      offset     <= mem_rd.q_fall;
      align_done <= 1'b1;
      align_fail <= |(~first_fall & ~mem_rd.q_fall);  // Pattern never seen on some lane
    end
  end

  // On-time lanes come from the held copy so every lane leaves on the late cycle
  assign rd_aligned.q_rise = lane_select(rd_q.q_rise, mem_rd.q_rise, offset);
  assign rd_aligned.q_fall = lane_select(rd_q.q_fall, mem_rd.q_fall, offset);

endmodule

// File: logic/qdrc_phy_sequencer.sv
`timescale 1ns/1ns
`include "qdrc_params.svh"

module qdrc_phy_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  qdrc_pkg::user_req_t user_req,
  input  qdrc_pkg::qdr_cmd_t  cal_cmd,
  input  logic                align_done,
  input  logic                align_fail,
  output logic                align_start,
  output qdrc_pkg::qdr_cmd_t  mem_cmd,
  output qdrc_pkg::rd_tag_t   rd_issue,
  output logic                cal_done,
  output logic                cal_fail
);

  localparam int DW = `QDRC_DATA_WIDTH;
  localparam int BW = `QDRC_BW_WIDTH;

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_CAL,
    S_RUN
  } state_t;

  state_t              state;
  logic                accept;       // User strobes are taken only after a clean calibration
  logic                run;
  logic                usr_w_n_q;
  logic                usr_r_n_q;
  qdrc_pkg::user_req_t req_q;        // Request sampled one cycle back
  logic [DW-1:0]       d_rise_q;     // Write data beat trails its command by a cycle
  logic [DW-1:0]       d_fall_q;
  logic [BW-1:0]       bw_n_rise_q;
  logic [BW-1:0]       bw_n_fall_q;
  qdrc_pkg::qdr_cmd_t  user_cmd;

  assign accept = align_done && !align_fail;
  assign run    = (state == S_RUN);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= S_IDLE;
      align_start <= 1'b0;
    end else begin
      align_start <= (state == S_START);  // One pulse as the FSM leaves START
      case (state)
        S_IDLE:  state <= S_START;
        S_START: state <= S_CAL;
        S_CAL: begin
          if (accept) begin
            state <= S_RUN;
          end
        end
        default: state <= S_RUN;  // RUN holds until reset
      endcase
    end
  end

  // Strobes are forced inactive whenever the request is not taken
  always_ff @(posedge clk) begin
    if (reset) begin
      usr_w_n_q <= 1'b1;
      usr_r_n_q <= 1'b1;
    end else begin
      usr_w_n_q <= !(accept && user_req.wr);
      usr_r_n_q <= !(accept && user_req.rd);
    end
  end

  always_ff @(posedge clk) begin
    req_q       <= user_req;
    d_rise_q    <= req_q.wdata_rise;
    d_fall_q    <= req_q.wdata_fall;
    bw_n_rise_q <= req_q.bw_n_rise;
    bw_n_fall_q <= req_q.bw_n_fall;
  end

  always_comb begin
    user_cmd.w_n       = usr_w_n_q;
    user_cmd.r_n       = usr_r_n_q;
    user_cmd.sa        = req_q.addr;
    user_cmd.d_rise    = d_rise_q;  // Beat of the write issued in the previous cycle
    user_cmd.d_fall    = d_fall_q;
    user_cmd.bw_n_rise = bw_n_rise_q;
    user_cmd.bw_n_fall = bw_n_fall_q;
  end

  assign mem_cmd        = run ? user_cmd : cal_cmd;  // Aligner owns the bus until RUN
  assign rd_issue.valid = run && !usr_r_n_q;         // Same cycle as the read on mem_cmd
  assign rd_issue.addr  = req_q.addr;

  assign cal_done = align_done;
  assign cal_fail = align_fail;

endmodule

// File: logic/qdrc_rd_tag_pipe.sv
`timescale 1ns/1ns
`include "qdrc_params.svh"

module qdrc_rd_tag_pipe #(
  // Read command cycle to the cycle where aligned read data is valid
  parameter int DEPTH = `QDRC_READ_LATENCY + 1
) (
  input  logic              clk,
  input  logic              reset,
  input  qdrc_pkg::rd_tag_t rd_issue,
  output qdrc_pkg::rd_tag_t user_rtag
);

  // One slot per cycle of flight so a read can enter every cycle
  qdrc_pkg::rd_tag_t stage [DEPTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;  // No stale tag survives a reset
      end
    end else begin
      stage[0] <= rd_issue;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // The last slot lines up with rd_aligned from the burst aligner
  assign user_rtag = stage[DEPTH-1];

endmodule

// File: logic/qdrc_phy.sv
`timescale 1ns/1ns

module qdrc_phy (
  input  logic                clk,
  input  logic                reset,
  input  qdrc_pkg::user_req_t user_req,
  input  qdrc_pkg::qdr_rd_t   mem_rd,
  output qdrc_pkg::qdr_cmd_t  mem_cmd,
  output qdrc_pkg::qdr_rd_t   user_rdata,
  output qdrc_pkg::rd_tag_t   user_rtag,
  output logic                cal_done,
  output logic                cal_fail
);

  logic               align_start;
  logic               align_done;
  logic               align_fail;
  qdrc_pkg::qdr_cmd_t cal_cmd;
  qdrc_pkg::rd_tag_t  rd_issue;

  // Owns the command bus and steps from calibration to user traffic
  qdrc_phy_sequencer u_sequencer (
    .clk         (clk),
    .reset       (reset),
    .user_req    (user_req),
    .cal_cmd     (cal_cmd),
    .align_done  (align_done),
    .align_fail  (align_fail),
    .align_start (align_start),
    .mem_cmd     (mem_cmd),
    .rd_issue    (rd_issue),
    .cal_done    (cal_done),
    .cal_fail    (cal_fail)
  );

  // Calibration pattern and per-lane re-timing of the read path
  qdrc_phy_burst_align u_burst_align (
    .clk         (clk),
    .reset       (reset),
    .align_start (align_start),
    .mem_rd      (mem_rd),
    .cal_cmd     (cal_cmd),
    .align_done  (align_done),
    .align_fail  (align_fail),
    .rd_aligned  (user_rdata)
  );

  qdrc_rd_tag_pipe u_rd_tag_pipe (
    .clk         (clk),
    .reset       (reset),
    .rd_issue    (rd_issue),
    .user_rtag   (user_rtag)
  );

endmodule

// File: tb/qdr_sram_model.sv
`timescale 1ns/1ns
`include "qdrc_params.svh"

module qdr_sram_model (
  input  logic                         clk,
  input  logic                         reset,
  input  qdrc_pkg::qdr_cmd_t           mem_cmd,
  input  logic [`QDRC_DATA_WIDTH-1:0]  late_mask,
  output qdrc_pkg::qdr_rd_t            mem_rd
);

  localparam int DW    = `QDRC_DATA_WIDTH;
  localparam int BW    = `QDRC_BW_WIDTH;
  localparam int BL    = DW / BW;  // Bits covered by one byte-write enable
  localparam int LAT   = `QDRC_READ_LATENCY;
  localparam int DEPTH = `QDRC_MODEL_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  logic [2*DW-1:0] mem [DEPTH];    // Rise word above the fall word
  logic            wr_pend;        // Write address seen, data beat is on the bus now
  logic [AW-1:0]   wr_addr;
  logic [2*DW-1:0] stage [LAT];    // Read words in flight, zero when idle
  logic [2*DW-1:0] q_late;         // Copy one cycle behind for late lanes
  logic [2*DW-1:0] merged;
  logic [2*DW-1:0] rd_word;

  function automatic logic [2*DW-1:0] merge_bytes(
    input logic [2*DW-1:0] old,
    input logic [DW-1:0]   rise,
    input logic [DW-1:0]   fall,
    input logic [BW-1:0]   bw_r,
    input logic [BW-1:0]   bw_f
  );
    logic [2*DW-1:0] w;
    w = old;
    for (int i = 0; i < BW; i++) begin
      for (int b = 0; b < BL; b++) begin
        if (!bw_r[i]) w[DW + i*BL + b] = rise[i*BL + b];
        if (!bw_f[i]) w[i*BL + b] = fall[i*BL + b];
      end
    end
    return w;
  endfunction

  assign merged = merge_bytes(mem[wr_addr], mem_cmd.d_rise, mem_cmd.d_fall,
                              mem_cmd.bw_n_rise, mem_cmd.bw_n_fall);

  // A read that meets the data beat of a pending write to the same word sees the new data
  assign rd_word = (wr_pend && wr_addr == mem_cmd.sa[AW-1:0]) ? merged
                                                               : mem[mem_cmd.sa[AW-1:0]];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_pend <= 1'b0;
      wr_addr <= '0;
      q_late  <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      for (int i = 0; i < LAT; i++) begin
        stage[i] <= '0;
      end
    end else begin
      wr_pend <= !mem_cmd.w_n;
      if (!mem_cmd.w_n) wr_addr <= mem_cmd.sa[AW-1:0];
      if (wr_pend) mem[wr_addr] <= merged;
      stage[0] <= mem_cmd.r_n ? '0 : rd_word;
      for (int i = 1; i < LAT; i++) begin
        stage[i] <= stage[i-1];
      end
      q_late <= stage[LAT-1];
    end
  end

  // On-time lanes show the word LAT cycles after the read, late lanes one cycle after that
  assign mem_rd.q_rise = (stage[LAT-1][2*DW-1:DW] & ~late_mask) | (q_late[2*DW-1:DW] & late_mask);
  assign mem_rd.q_fall = (stage[LAT-1][DW-1:0] & ~late_mask) | (q_late[DW-1:0] & late_mask);

endmodule

// File: tb/tb_qdrc_phy.sv
`timescale 1ns/1ns
`include "qdrc_params.svh"

module tb_qdrc_phy;

  localparam int DW      = `QDRC_DATA_WIDTH;
  localparam int BW      = `QDRC_BW_WIDTH;
  localparam int BL      = DW / BW;
  localparam int AW      = `QDRC_ADDR_WIDTH;
  localparam int LAT     = `QDRC_READ_LATENCY;
  localparam int TRAFFIC = 200;
  localparam int DRAIN   = 40;
  localparam int LIMIT   = 8 + 40 + TRAFFIC + DRAIN;  // Cycles of reset, calibration, traffic and drain

  logic                clk;
  logic                reset;
  qdrc_pkg::user_req_t user_req;
  qdrc_pkg::qdr_rd_t   mem_rd;
  qdrc_pkg::qdr_cmd_t  mem_cmd;
  qdrc_pkg::qdr_rd_t   user_rdata;
  qdrc_pkg::rd_tag_t   user_rtag;
  logic                cal_done;
  logic                cal_fail;
  logic [DW-1:0]       late_mask;

  integer          seed = 39966;
  int              mismatches = 0;
  int              cyc = 0;
  logic [2*DW-1:0] shadow [16];    // Expected memory, rise word above fall word
  int              exp_cyc [$];    // Cycle on which each read must come back
  logic [AW-1:0]   exp_addr [$];
  logic [2*DW-1:0] exp_data [$];
  logic            cal_wr_seen = 1'b0;
  logic            cal_rd_checked = 1'b0;
  logic            cal_done_q = 1'b0;
  int              cal_wr_cyc = 0;

  qdrc_phy DUT (
    .clk        (clk),
    .reset      (reset),
    .user_req   (user_req),
    .mem_rd     (mem_rd),
    .mem_cmd    (mem_cmd),
    .user_rdata (user_rdata),
    .user_rtag  (user_rtag),
    .cal_done   (cal_done),
    .cal_fail   (cal_fail)
  );

  qdr_sram_model sram (
    .clk       (clk),
    .reset     (reset),
    .mem_cmd   (mem_cmd),
    .late_mask (late_mask),
    .mem_rd    (mem_rd)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    mismatches++;
  endtask

  // Byte enables are active low so a high bit keeps the old byte
  function automatic logic [2*DW-1:0] apply_byte_writes(
    input logic [2*DW-1:0] old,
    input logic [DW-1:0]   rise,
    input logic [DW-1:0]   fall,
    input logic [BW-1:0]   bw_r,
    input logic [BW-1:0]   bw_f
  );
    logic [2*DW-1:0] w;
    w = old;
    for (int i = 0; i < BW; i++) begin
      if (!bw_r[i]) w[DW + i*BL +: BL] = rise[i*BL +: BL];
      if (!bw_f[i]) w[i*BL +: BL] = fall[i*BL +: BL];
    end
    return w;
  endfunction

  task automatic drive_random_request(input logic force_rd);
    logic [63:0]         r_rise;
    logic [63:0]         r_fall;
    logic [31:0]         r;
    qdrc_pkg::user_req_t req;
    r_rise         = {$random(seed), $random(seed)};
    r_fall         = {$random(seed), $random(seed)};
    r              = $random(seed);
    req.wr         = r[0];
    req.rd         = r[1] | force_rd;
    req.addr       = {{(AW-4){1'b0}}, r[5:2]};  // Stay inside the model depth
    req.wdata_rise = r_rise[DW-1:0];
    req.wdata_fall = r_fall[DW-1:0];
    req.bw_n_rise  = r[6 +: BW];
    req.bw_n_fall  = r[10 +: BW];
    user_req <= req;
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == LIMIT) begin
      $display("Timeout: test did not finish");
      $display("Test failures found");
      $finish;
    end
  end

  // Scoreboard and bus checks, once per cycle half a clock after the outputs change
  always @(negedge clk) begin
    logic [3:0] idx;
    idx = user_req.addr[3:0];
    if (!cal_wr_seen) begin
      if (!mem_cmd.w_n) begin
        assert (mem_cmd.sa == '0) else report_mismatch("calibration write address not zero");
        cal_wr_seen = 1'b1;
        cal_wr_cyc  = cyc;
      end else begin
        assert (mem_cmd.r_n) else report_mismatch("read strobe before calibration write");
      end
    end else if (!cal_rd_checked) begin
      assert (!mem_cmd.r_n && mem_cmd.w_n && mem_cmd.sa == '0)
        else report_mismatch("calibration read missing or not at address zero");
      assert (mem_cmd.d_fall == '1 && mem_cmd.d_rise == '0)
        else report_mismatch("calibration data beat is not the fall ones pattern");
      cal_rd_checked = 1'b1;
    end else if (!cal_done_q) begin
      assert (mem_cmd.w_n && mem_cmd.r_n) else report_mismatch("memory command before cal_done");
    end
    if (cal_done && !cal_done_q) begin
      assert (cal_wr_seen && cyc - cal_wr_cyc == LAT + 3)
        else report_mismatch("cal_done rose on the wrong cycle");
    end
    if (cal_done_q) begin
      assert (cal_done) else report_mismatch("cal_done dropped");
    end
    assert (!cal_fail) else report_mismatch("cal_fail set");
    cal_done_q = cal_done;

    if (exp_cyc.size() > 0 && exp_cyc[0] == cyc) begin
      assert (user_rtag.valid) else report_mismatch("read tag not valid on data cycle");
      assert (user_rtag.addr == exp_addr[0]) else report_mismatch("read tag address wrong");
      assert (user_rdata == exp_data[0]) else report_mismatch("read data differs from shadow");
      void'(exp_cyc.pop_front());
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
    end else begin
      assert (!user_rtag.valid) else report_mismatch("tag valid with no read outstanding");
    end

    // The read of a cycle sees writes from earlier cycles only
    if (cal_done && user_req.rd) begin
      exp_cyc.push_back(cyc + LAT + 2);
      exp_addr.push_back(user_req.addr);
      exp_data.push_back(shadow[idx]);
    end
    if (cal_done && user_req.wr) begin
      shadow[idx] = apply_byte_writes(shadow[idx], user_req.wdata_rise, user_req.wdata_fall,
                                      user_req.bw_n_rise, user_req.bw_n_fall);
    end
  end

  initial begin
    logic [63:0] r64;
    reset    = 1'b1;
    user_req = '0;
    r64      = {$random(seed), $random(seed)};
    late_mask = r64[DW-1:0];
    for (int i = 0; i < 16; i++) begin
      shadow[i] = '0;
    end
    shadow[0] = {{DW{1'b0}}, {DW{1'b1}}};  // Left there by the calibration write
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    while (!cal_done) begin
      @(posedge clk);
      drive_random_request(1'b0);  // Dropped while cal_done is low
    end
    for (int i = 0; i < TRAFFIC; i++) begin
      @(posedge clk);
      drive_random_request(i >= 80 && i < 100);  // A run of back-to-back reads
    end
    @(posedge clk);
    user_req <= '0;
    repeat (DRAIN) @(posedge clk);
    $display("Errors: %0d mismatches", mismatches);
    if (mismatches == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
logic/qdrc_pkg.sv
logic/qdrc_phy_burst_align.sv
logic/qdrc_phy_sequencer.sv
logic/qdrc_rd_tag_pipe.sv
logic/qdrc_phy.sv
tb/qdr_sram_model.sv
tb/tb_qdrc_phy.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the QDR PHY testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_qdrc_phy \
  -Mdir obj_dir

./obj_dir/Vtb_qdrc_phy > sim.log
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation passed"
exit 0
